/* verilog.f */
source/hk_pkg.sv
source/hk_bus_fsm.sv
source/hk_timer.sv
source/hk_gpio_pads.sv
source/hk_readback.sv
source/hk_top.sv
tests/hk_tb.sv

/* Bender.yml */
package:
  name: hk_regs

sources:
  - source/hk_pkg.sv
  - source/hk_bus_fsm.sv
  - source/hk_timer.sv
  - source/hk_gpio_pads.sv
  - source/hk_readback.sv
  - source/hk_top.sv
  - target: test
    files:
      - tests/hk_tb.sv

/* tests/hk_tb.sv */
`timescale 1ns/1ps

module hk_tb;

  localparam int TBL_LEN = 45;
  localparam int TIMER_CYCLES = 160;
  localparam int MARGIN = 400;
  localparam int TIMEOUT_CYCLES = TBL_LEN * 8 + TIMER_CYCLES + MARGIN;
  localparam logic [31:0] SEED = 32'hbd7e_fcd7;

  // fixed status inputs
  localparam logic [7:0] CFG_V = 8'ha5;
  localparam logic [3:0] TRIM_V = 4'h9;
  localparam logic [11:0] MFGR_V = 12'h456;
  localparam logic [7:0] PROD_V = 8'h3c;
  localparam logic [3:0] MASK_V = 4'h2;

  logic clk_i;
  logic rst_n_i;
  logic mem_valid_i;
  hk_pkg::addr_t mem_addr_i;
  hk_pkg::word_t mem_wdata_i;
  hk_pkg::strb_t mem_wstrb_i;
  logic mem_ready_o;
  hk_pkg::word_t mem_rdata_o;
  hk_pkg::pad_vec_t gpio_in_i;
  hk_pkg::pad_vec_t gpio_out_o;
  hk_pkg::pad_vec_t gpio_outenb_o;
  hk_pkg::pad_vec_t gpio_pullupb_o;
  hk_pkg::pad_vec_t gpio_pulldownb_o;
  logic trap_i;
  logic [hk_pkg::IRQ_WIDTH-1:0] irq_o;

  logic [31:0] lfsr_q;
  int cycle_cnt;
  int checks;
  int errors;
  int pulse_stamps[$];
  hk_pkg::pad_vec_t in_pattern;

  logic tbl_wr [TBL_LEN];
  hk_pkg::addr_t tbl_addr [TBL_LEN];
  hk_pkg::word_t tbl_wdata [TBL_LEN];
  hk_pkg::strb_t tbl_wstrb [TBL_LEN];
  hk_pkg::word_t tbl_exp [TBL_LEN];
  int tbl_n;

  hk_top dut_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .mem_valid_i       (mem_valid_i),
    .mem_addr_i        (mem_addr_i),
    .mem_wdata_i       (mem_wdata_i),
    .mem_wstrb_i       (mem_wstrb_i),
    .mem_ready_o       (mem_ready_o),
    .mem_rdata_o       (mem_rdata_o),
    .gpio_in_i         (gpio_in_i),
    .gpio_out_o        (gpio_out_o),
    .gpio_outenb_o     (gpio_outenb_o),
    .gpio_pullupb_o    (gpio_pullupb_o),
    .gpio_pulldownb_o  (gpio_pulldownb_o),
    .trap_i            (trap_i),
    .ro_config_i       (CFG_V),
    .ro_xtal_ena_i     (1'b1),
    .ro_reg_ena_i      (1'b0),
    .ro_pll_trim_i     (TRIM_V),
    .ro_pll_cp_ena_i   (1'b1),
    .ro_pll_vco_ena_i  (1'b0),
    .ro_pll_bias_ena_i (1'b1),
    .ro_mfgr_id_i      (MFGR_V),
    .ro_prod_id_i      (PROD_V),
    .ro_mask_rev_i     (MASK_V),
    .clk_ext_sel_i     (1'b1),
    .irq_o             (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input logic wr, input hk_pkg::reg_ofs_t ofs, input hk_pkg::word_t wdata,
                           input hk_pkg::strb_t wstrb, input hk_pkg::word_t exp);
    tbl_wr[tbl_n] = wr;
    tbl_addr[tbl_n] = {hk_pkg::HK_WINDOW, ofs};
    tbl_wdata[tbl_n] = wdata;
    tbl_wstrb[tbl_n] = wstrb;
    tbl_exp[tbl_n] = exp;
    tbl_n++;
  endtask

  // register model merges only strobed bytes
  task automatic build_table();
    hk_pkg::pad_vec_t pad_model [4];
    hk_pkg::route_sel_t route_model [4];
    hk_pkg::reg_ofs_t pad_ofs [4];
    hk_pkg::reg_ofs_t route_ofs [4];
    hk_pkg::word_t wdata;
    hk_pkg::word_t exp;
    hk_pkg::strb_t wstrb;
    int rnd;
    int r;
    pad_model = '{16'h0000, 16'hffff, 16'h0000, 16'h0000};
    route_model = '{2'd0, 2'd0, 2'd0, 2'd0};
    pad_ofs = '{hk_pkg::GPIO_DATA_OFS, hk_pkg::GPIO_OEB_OFS, hk_pkg::GPIO_PU_OFS,
                hk_pkg::GPIO_PD_OFS};
    route_ofs = '{hk_pkg::PLL_DEST_OFS, hk_pkg::TRAP_DEST_OFS, hk_pkg::IRQ7_SRC_OFS,
                  hk_pkg::IRQ8_SRC_OFS};
    tbl_n = 0;
    for (rnd = 0; rnd < 2; rnd++) begin
      for (r = 0; r < 4; r++) begin
        wdata = rand_bits(32);
        wstrb = rand_bits(4);
        add_entry(1'b1, pad_ofs[r], wdata, wstrb, '0);
        if (wstrb[0]) pad_model[r][7:0] = wdata[7:0];
        if (wstrb[1]) pad_model[r][15:8] = wdata[15:8];
        // data reads back as {pad outputs, pad inputs}
        exp = (r == 0) ? {pad_model[0], in_pattern} : {16'd0, pad_model[r]};
        add_entry(1'b0, pad_ofs[r], '0, '0, exp);
      end
    end
    for (rnd = 0; rnd < 2; rnd++) begin
      for (r = 0; r < 4; r++) begin
        wdata = rand_bits(32);
        wstrb = rand_bits(4);
        add_entry(1'b1, route_ofs[r], wdata, wstrb, '0);
        if (wstrb[0]) route_model[r] = wdata[1:0];
        add_entry(1'b0, route_ofs[r], '0, '0, {30'd0, route_model[r]});
      end
    end
    for (r = 0; r < 4; r++) begin
      add_entry(1'b1, route_ofs[r], '0, 4'hf, '0);
    end
    add_entry(1'b0, hk_pkg::CONFIG_OFS, '0, '0, {24'd0, CFG_V});
    add_entry(1'b0, hk_pkg::ENA_OFS, '0, '0, {30'd0, 1'b1, 1'b0});
    add_entry(1'b0, hk_pkg::PLL_OFS, '0, '0, {25'd0, TRIM_V, 1'b1, 1'b0, 1'b1});
    add_entry(1'b0, hk_pkg::MFGR_OFS, '0, '0, {20'd0, MFGR_V});
    add_entry(1'b0, hk_pkg::PROD_OFS, '0, '0, {24'd0, PROD_V});
    add_entry(1'b0, hk_pkg::MASK_OFS, '0, '0, {28'd0, MASK_V});
    add_entry(1'b0, hk_pkg::CLKSEL_OFS, '0, '0, 32'd1);
    // status words ignore writes
    add_entry(1'b1, hk_pkg::CONFIG_OFS, 32'hffff_ffff, 4'hf, '0);
    add_entry(1'b0, hk_pkg::CONFIG_OFS, '0, '0, {24'd0, CFG_V});
  endtask

  // one access with ready expected one cycle after the access edge
  task automatic bus_access(input logic wr, input hk_pkg::addr_t addr, input hk_pkg::word_t wdata,
                            input hk_pkg::strb_t wstrb, output hk_pkg::word_t rdata,
                            output int stamp);
    int waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    rdata = '0;
    stamp = 0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= wr ? wstrb : 4'h0;
    while (!seen && waited < 10) begin
      @(negedge clk_i);
      waited++;
      if (mem_ready_o) begin
        seen = 1'b1;
        rdata = mem_rdata_o;
        stamp = cycle_cnt;
      end
    end
    if (!seen) begin
      errors++;
      $display("access to address %h was never answered", addr);
    end else if (waited != 2) begin
      errors++;
      $display("ERR t=%0t mem_ready_o latency got %0d exp 2", $time, waited);
    end
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= 4'h0;
  endtask

  task automatic write_reg(input hk_pkg::reg_ofs_t ofs, input hk_pkg::word_t wdata);
    hk_pkg::word_t rdata;
    int stamp;
    bus_access(1'b1, {hk_pkg::HK_WINDOW, ofs}, wdata, 4'hf, rdata, stamp);
  endtask

  task automatic read_reg(input hk_pkg::reg_ofs_t ofs, output hk_pkg::word_t rdata);
    int stamp;
    bus_access(1'b0, {hk_pkg::HK_WINDOW, ofs}, '0, '0, rdata, stamp);
  endtask

  task automatic collect_pulses(input int bit_idx, input int ncycles);
    int i;
    pulse_stamps.delete();
    for (i = 0; i < ncycles; i++) begin
      @(negedge clk_i);
      if (irq_o[bit_idx]) pulse_stamps.push_back(cycle_cnt);
    end
  endtask

  task automatic expect_no_answer(input hk_pkg::addr_t addr);
    int i;
    logic seen;
    seen = 1'b0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i <= addr;
    mem_wstrb_i <= 4'h0;
    for (i = 0; i < 10; i++) begin
      @(negedge clk_i);
      if (mem_ready_o) seen = 1'b1;
    end
    checks++;
    if (seen) begin
      errors++;
      $display("access outside the window at %h was answered", addr);
    end
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
  endtask

  initial begin
    hk_pkg::word_t tmp;
    hk_pkg::word_t rdata;
    hk_pkg::word_t pat;
    int stamp;
    int start;
    int i;
    int src;
    int k;
    int n_cnt;
    int n_val;
    checks = 0;
    errors = 0;
    lfsr_q = SEED;
    tmp = rand_bits(16);
    in_pattern = tmp[15:0];
    rst_n_i = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    gpio_in_i = in_pattern;
    trap_i = 1'b0;
    build_table();
    if (tbl_n != TBL_LEN) begin
      errors++;
      $display("stimulus table holds %0d entries instead of %0d", tbl_n, TBL_LEN);
    end

    // reset state during and after reset
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_val("gpio_outenb_o", gpio_outenb_o, 32'h0000_ffff);
    check_val("mem_ready_o", mem_ready_o, 0);
    check_val("irq_o", irq_o, 0);
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("gpio_outenb_o", gpio_outenb_o, 32'h0000_ffff);
    check_val("mem_ready_o", mem_ready_o, 0);
    check_val("irq_o", irq_o, 0);

    for (i = 0; i < TBL_LEN; i++) begin
      bus_access(tbl_wr[i], tbl_addr[i], tbl_wdata[i], tbl_wstrb[i], rdata, stamp);
      if (!tbl_wr[i]) check_val("mem_rdata_o", rdata, tbl_exp[i]);
    end

    // pads 8 and 12 disabled with pulls on before routing
    write_reg(hk_pkg::GPIO_OEB_OFS, 32'h0000_f1e1);
    write_reg(hk_pkg::GPIO_PU_OFS, 32'h0000_0a5a);
    write_reg(hk_pkg::GPIO_PD_OFS, 32'h0000_05a5);
    @(negedge clk_i);
    check_val("gpio_outenb_o", gpio_outenb_o, 32'h0000_f1e1);
    check_val("gpio_pullupb_o", gpio_pullupb_o, 32'h0000_0a5a);
    check_val("gpio_pulldownb_o", gpio_pulldownb_o, 32'h0000_05a5);

    // trap onto pad 12 and clock onto pad 8
    write_reg(hk_pkg::TRAP_DEST_OFS, 32'd2);
    @(posedge clk_i);
    trap_i <= 1'b1;
    @(negedge clk_i);
    check_val("gpio_out_o[12]", gpio_out_o[12], 1);
    check_val("gpio_outenb_o[12]", gpio_outenb_o[12], 0);
    check_val("gpio_pullupb_o[12]", gpio_pullupb_o[12], 1);
    check_val("gpio_pulldownb_o[12]", gpio_pulldownb_o[12], 1);
    @(posedge clk_i);
    trap_i <= 1'b0;
    @(negedge clk_i);
    check_val("gpio_out_o[12]", gpio_out_o[12], 0);
    write_reg(hk_pkg::PLL_DEST_OFS, 32'd1);
    @(negedge clk_i);
    check_val("gpio_outenb_o[8]", gpio_outenb_o[8], 0);
    write_reg(hk_pkg::PLL_DEST_OFS, 32'd0);
    write_reg(hk_pkg::TRAP_DEST_OFS, 32'd0);

    // irq 7 from gpio 0..2 and irq 8 from gpio 3..5
    for (src = 0; src < 4; src++) begin
      write_reg(hk_pkg::IRQ7_SRC_OFS, src);
      write_reg(hk_pkg::IRQ8_SRC_OFS, src);
      repeat (4) begin
        pat = rand_bits(16);
        @(posedge clk_i);
        gpio_in_i <= pat[15:0];
        @(negedge clk_i);
        check_val("irq_o[0]", irq_o[0], (src == 0) ? 1'b0 : pat[src - 1]);
        check_val("irq_o[1]", irq_o[1], (src == 0) ? 1'b0 : pat[src + 2]);
      end
    end

    // timer 0 continuous
    n_cnt = 3 + rand_bits(3);
    n_val = 2 + rand_bits(3);
    write_reg(hk_pkg::TIM0_BASE + hk_pkg::TIM_VAL_REL, n_val);
    write_reg(hk_pkg::TIM0_BASE + hk_pkg::TIM_DAT_REL, n_cnt);
    bus_access(1'b1, {hk_pkg::HK_WINDOW, hk_pkg::TIM0_BASE + hk_pkg::TIM_CFG_REL},
               (1 << hk_pkg::TIM_EN_BIT) | (1 << hk_pkg::TIM_IRQEN_BIT), 4'hf, rdata, start);
    collect_pulses(2, n_cnt + 1 + 2 * (n_val + 1) + 2);
    if (pulse_stamps.size() < 3) begin
      errors++;
      $display("timer 0 gave %0d irq pulses where at least 3 were due", pulse_stamps.size());
    end else begin
      check_val("tim0 first irq cycle", pulse_stamps[0], start + n_cnt + 1);
      for (k = 1; k < 3; k++) begin
        check_val("tim0 irq interval", pulse_stamps[k] - pulse_stamps[k - 1], n_val + 1);
      end
    end
    write_reg(hk_pkg::TIM0_BASE + hk_pkg::TIM_CFG_REL, 32'd0);

    // timer 1 one-shot
    n_cnt = 3 + rand_bits(3);
    write_reg(hk_pkg::TIM1_BASE + hk_pkg::TIM_DAT_REL, n_cnt);
    write_reg(hk_pkg::TIM1_BASE + hk_pkg::TIM_CFG_REL, 32'd7);
    collect_pulses(3, 3 * (n_cnt + 1) + 8);
    checks++;
    if (pulse_stamps.size() != 1) begin
      errors++;
      $display("timer 1 one-shot gave %0d irq pulses instead of one", pulse_stamps.size());
    end
    read_reg(hk_pkg::TIM1_BASE + hk_pkg::TIM_CFG_REL, rdata);
    check_val("tim1 cfg", rdata,
              (1 << hk_pkg::TIM_ONESHOT_BIT) | (1 << hk_pkg::TIM_IRQEN_BIT));

    expect_no_answer({hk_pkg::HK_WINDOW + 24'd1, 8'h00});

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* source/hk_top.sv */
`timescale 1ns/1ps

module hk_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         mem_valid_i,
  input  hk_pkg::addr_t                mem_addr_i,
  input  hk_pkg::word_t                mem_wdata_i,
  input  hk_pkg::strb_t                mem_wstrb_i,
  output logic                         mem_ready_o,
  output hk_pkg::word_t                mem_rdata_o,
  input  hk_pkg::pad_vec_t             gpio_in_i,
  output hk_pkg::pad_vec_t             gpio_out_o,
  output hk_pkg::pad_vec_t             gpio_outenb_o,
  output hk_pkg::pad_vec_t             gpio_pullupb_o,
  output hk_pkg::pad_vec_t             gpio_pulldownb_o,
  input  logic                         trap_i,
  input  logic [7:0]                   ro_config_i,
  input  logic                         ro_xtal_ena_i,
  input  logic                         ro_reg_ena_i,
  input  logic [3:0]                   ro_pll_trim_i,
  input  logic                         ro_pll_cp_ena_i,
  input  logic                         ro_pll_vco_ena_i,
  input  logic                         ro_pll_bias_ena_i,
  input  logic [11:0]                  ro_mfgr_id_i,
  input  logic [7:0]                   ro_prod_id_i,
  input  logic [3:0]                   ro_mask_rev_i,
  input  logic                         clk_ext_sel_i,
  output logic [hk_pkg::IRQ_WIDTH-1:0] irq_o
);

  logic             access;
  hk_pkg::reg_ofs_t ofs;
  hk_pkg::word_t    gpio_rdata;
  hk_pkg::word_t    tim0_rdata;
  hk_pkg::word_t    tim1_rdata;
  logic             tim0_irq;
  logic             tim1_irq;
  logic [1:0]       irq_ext;

  assign ofs = mem_addr_i[7:0];

  hk_bus_fsm u_bus_fsm (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .access_o    (access),
    .mem_ready_o (mem_ready_o)
  );

  hk_gpio_pads u_gpio_pads (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .access_i         (access),
    .ofs_i            (ofs),
    .wdata_i          (mem_wdata_i),
    .wstrb_i          (mem_wstrb_i),
    .trap_i           (trap_i),
    .gpio_in_i        (gpio_in_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_ext_o        (irq_ext),
    .rdata_o          (gpio_rdata)
  );

  hk_timer #(
    .TIMER_BASE (hk_pkg::TIM0_BASE)
  ) u_timer0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .access_i (access),
    .ofs_i    (ofs),
    .wdata_i  (mem_wdata_i),
    .wstrb_i  (mem_wstrb_i),
    .rdata_o  (tim0_rdata),
    .irq_o    (tim0_irq)
  );

  hk_timer #(
    .TIMER_BASE (hk_pkg::TIM1_BASE)
  ) u_timer1 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .access_i (access),
    .ofs_i    (ofs),
    .wdata_i  (mem_wdata_i),
    .wstrb_i  (mem_wstrb_i),
    .rdata_o  (tim1_rdata),
    .irq_o    (tim1_irq)
  );

  hk_readback u_readback (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .access_i          (access),
    .ofs_i             (ofs),
    .gpio_rdata_i      (gpio_rdata),
    .tim0_rdata_i      (tim0_rdata),
    .tim1_rdata_i      (tim1_rdata),
    .ro_config_i       (ro_config_i),
    .ro_xtal_ena_i     (ro_xtal_ena_i),
    .ro_reg_ena_i      (ro_reg_ena_i),
    .ro_pll_trim_i     (ro_pll_trim_i),
    .ro_pll_cp_ena_i   (ro_pll_cp_ena_i),
    .ro_pll_vco_ena_i  (ro_pll_vco_ena_i),
    .ro_pll_bias_ena_i (ro_pll_bias_ena_i),
    .ro_mfgr_id_i      (ro_mfgr_id_i),
    .ro_prod_id_i      (ro_prod_id_i),
    .ro_mask_rev_i     (ro_mask_rev_i),
    .clk_ext_sel_i     (clk_ext_sel_i),
    .mem_rdata_o       (mem_rdata_o)
  );

  // timer 1, timer 0, irq 8, irq 7
  assign irq_o = {tim1_irq, tim0_irq, irq_ext};

endmodule

/* source/hk_readback.sv */
`timescale 1ns/1ps

module hk_readback (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             access_i,
  input  hk_pkg::reg_ofs_t ofs_i,
  input  hk_pkg::word_t    gpio_rdata_i,
  input  hk_pkg::word_t    tim0_rdata_i,
  input  hk_pkg::word_t    tim1_rdata_i,
  input  logic [7:0]       ro_config_i,
  input  logic             ro_xtal_ena_i,
  input  logic             ro_reg_ena_i,
  input  logic [3:0]       ro_pll_trim_i,
  input  logic             ro_pll_cp_ena_i,
  input  logic             ro_pll_vco_ena_i,
  input  logic             ro_pll_bias_ena_i,
  input  logic [11:0]      ro_mfgr_id_i,
  input  logic [7:0]       ro_prod_id_i,
  input  logic [3:0]       ro_mask_rev_i,
  input  logic             clk_ext_sel_i,
  output hk_pkg::word_t    mem_rdata_o
);

  hk_pkg::word_t status_word;
  hk_pkg::word_t rdata_d;

  // read-only status, zero-extended
  always_comb begin
    case (ofs_i)
      hk_pkg::CONFIG_OFS: begin
        status_word = {24'd0, ro_config_i};
      end
      hk_pkg::ENA_OFS: begin
        status_word = {30'd0, ro_xtal_ena_i, ro_reg_ena_i};
      end
      hk_pkg::PLL_OFS: begin
        status_word = {
          25'd0,
          ro_pll_trim_i,
          ro_pll_cp_ena_i,
          ro_pll_vco_ena_i,
          ro_pll_bias_ena_i
        };
      end
      hk_pkg::MFGR_OFS: begin
        status_word = {20'd0, ro_mfgr_id_i};
      end
      hk_pkg::PROD_OFS: begin
        status_word = {24'd0, ro_prod_id_i};
      end
      hk_pkg::MASK_OFS: begin
        status_word = {28'd0, ro_mask_rev_i};
      end
      hk_pkg::CLKSEL_OFS: begin
        status_word = {31'd0, clk_ext_sel_i};
      end
      default: begin
        status_word = '0;
      end
    endcase
  end

  // each source is zero outside its own offsets
  assign rdata_d = gpio_rdata_i | tim0_rdata_i | tim1_rdata_i | status_word;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_rdata_o <= '0;
    end else if (access_i) begin
      mem_rdata_o <= rdata_d;
    end
  end

endmodule

/* source/hk_gpio_pads.sv */
`timescale 1ns/1ps

module hk_gpio_pads (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               access_i,
  input  hk_pkg::reg_ofs_t   ofs_i,
  input  hk_pkg::word_t      wdata_i,
  input  hk_pkg::strb_t      wstrb_i,
  input  logic               trap_i,
  input  hk_pkg::pad_vec_t   gpio_in_i,
  output hk_pkg::pad_vec_t   gpio_out_o,
  output hk_pkg::pad_vec_t   gpio_outenb_o,
  output hk_pkg::pad_vec_t   gpio_pullupb_o,
  output hk_pkg::pad_vec_t   gpio_pulldownb_o,
  output logic [1:0]         irq_ext_o,
  output hk_pkg::word_t      rdata_o
);

  hk_pkg::pad_vec_t   data_q;
  hk_pkg::pad_vec_t   oeb_q;
  hk_pkg::pad_vec_t   pu_q;
  hk_pkg::pad_vec_t   pd_q;
  hk_pkg::route_sel_t pll_dest_q;
  hk_pkg::route_sel_t trap_dest_q;
  hk_pkg::route_sel_t irq7_src_q;
  hk_pkg::route_sel_t irq8_src_q;
  hk_pkg::pad_vec_t   oeb_routed;
  logic               pll_routed;
  logic               trap_routed;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_q      <= '0;
      oeb_q       <= '1;
      pu_q        <= '0;
      pd_q        <= '0;
      pll_dest_q  <= '0;
      trap_dest_q <= '0;
      irq7_src_q  <= '0;
      irq8_src_q  <= '0;
    end else if (access_i) begin
      // pad registers use byte lanes 0 and 1
      for (int b = 0; b < 2; b++) begin
        if (wstrb_i[b]) begin
          case (ofs_i)
            hk_pkg::GPIO_DATA_OFS: data_q[8*b +: 8] <= wdata_i[8*b +: 8];
            hk_pkg::GPIO_OEB_OFS:  oeb_q[8*b +: 8] <= wdata_i[8*b +: 8];
            hk_pkg::GPIO_PU_OFS:   pu_q[8*b +: 8] <= wdata_i[8*b +: 8];
            hk_pkg::GPIO_PD_OFS:   pd_q[8*b +: 8] <= wdata_i[8*b +: 8];
            default: ;
          endcase
        end
      end
      if (wstrb_i[0]) begin
        case (ofs_i)
          hk_pkg::PLL_DEST_OFS:  pll_dest_q <= wdata_i[1:0];
          hk_pkg::TRAP_DEST_OFS: trap_dest_q <= wdata_i[1:0];
          hk_pkg::IRQ7_SRC_OFS:  irq7_src_q <= wdata_i[1:0];
          hk_pkg::IRQ8_SRC_OFS:  irq8_src_q <= wdata_i[1:0];
          default: ;
        endcase
      end
    end
  end

  assign pll_routed  = (pll_dest_q != 2'd0);
  assign trap_routed = (trap_dest_q != 2'd0);

  // clock onto pad 8/9, trap onto pad 11/12/13
  always_comb begin
    gpio_out_o = data_q;
    if (pll_dest_q == 2'd1) gpio_out_o[8] = clk_i;
    if (pll_dest_q == 2'd2) gpio_out_o[9] = clk_i;
    if (trap_dest_q == 2'd1) gpio_out_o[11] = trap_i;
    if (trap_dest_q == 2'd2) gpio_out_o[12] = trap_i;
    if (trap_dest_q == 2'd3) gpio_out_o[13] = trap_i;
  end

  // routed pads driven, pulls off
  always_comb begin
    oeb_routed       = oeb_q;
    gpio_pullupb_o   = pu_q;
    gpio_pulldownb_o = pd_q;
    if (pll_routed) begin
      oeb_routed[10:8]       = 3'b000;
      gpio_pullupb_o[10:8]   = 3'b111;
      gpio_pulldownb_o[10:8] = 3'b111;
    end
    if (trap_routed) begin
      oeb_routed[13:11]       = 3'b000;
      gpio_pullupb_o[13:11]   = 3'b111;
      gpio_pulldownb_o[13:11] = 3'b111;
    end
  end

  // pads stay tristated while in reset
  assign gpio_outenb_o = oeb_routed | {16{~rst_n_i}};

  always_comb begin
    case (irq7_src_q)
      2'd1:    irq_ext_o[0] = gpio_in_i[0];
      2'd2:    irq_ext_o[0] = gpio_in_i[1];
      2'd3:    irq_ext_o[0] = gpio_in_i[2];
      default: irq_ext_o[0] = 1'b0;
    endcase
    case (irq8_src_q)
      2'd1:    irq_ext_o[1] = gpio_in_i[3];
      2'd2:    irq_ext_o[1] = gpio_in_i[4];
      2'd3:    irq_ext_o[1] = gpio_in_i[5];
      default: irq_ext_o[1] = 1'b0;
    endcase
  end

  always_comb begin
    case (ofs_i)
      hk_pkg::GPIO_DATA_OFS: rdata_o = {gpio_out_o, gpio_in_i};
      hk_pkg::GPIO_OEB_OFS:  rdata_o = {16'd0, oeb_q};
      hk_pkg::GPIO_PU_OFS:   rdata_o = {16'd0, pu_q};
      hk_pkg::GPIO_PD_OFS:   rdata_o = {16'd0, pd_q};
      hk_pkg::PLL_DEST_OFS:  rdata_o = {30'd0, pll_dest_q};
      hk_pkg::TRAP_DEST_OFS: rdata_o = {30'd0, trap_dest_q};
      hk_pkg::IRQ7_SRC_OFS:  rdata_o = {30'd0, irq7_src_q};
      hk_pkg::IRQ8_SRC_OFS:  rdata_o = {30'd0, irq8_src_q};
      default:               rdata_o = '0;
    endcase
  end

endmodule

/* source/hk_timer.sv */
`timescale 1ns/1ps

module hk_timer #(
  parameter hk_pkg::reg_ofs_t TIMER_BASE = hk_pkg::TIM0_BASE
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             access_i,
  input  hk_pkg::reg_ofs_t ofs_i,
  input  hk_pkg::word_t    wdata_i,
  input  hk_pkg::strb_t    wstrb_i,
  output hk_pkg::word_t    rdata_o,
  output logic             irq_o
);

  logic [2:0]    cfg_q;
  hk_pkg::word_t val_q;
  hk_pkg::word_t cnt_q;
  logic          cfg_sel;
  logic          val_sel;
  logic          dat_sel;
  logic          enabled;

  assign cfg_sel = (ofs_i == TIMER_BASE + hk_pkg::TIM_CFG_REL);
  assign val_sel = (ofs_i == TIMER_BASE + hk_pkg::TIM_VAL_REL);
  assign dat_sel = (ofs_i == TIMER_BASE + hk_pkg::TIM_DAT_REL);

  assign enabled = cfg_q[hk_pkg::TIM_EN_BIT];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= 3'b000;
      val_q <= '0;
      cnt_q <= '0;
      irq_o <= 1'b0;
    end else begin
      irq_o <= 1'b0;
      if (enabled) begin
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 32'd1;
        end else begin
          irq_o <= cfg_q[hk_pkg::TIM_IRQEN_BIT];
          if (cfg_q[hk_pkg::TIM_ONESHOT_BIT]) begin
            cfg_q[hk_pkg::TIM_EN_BIT] <= 1'b0;
          end else begin
            cnt_q <= val_q;
          end
        end
      end
      // bus writes take priority over counting
      if (access_i) begin
        if (cfg_sel && wstrb_i[0]) begin
          cfg_q <= wdata_i[2:0];
        end
        for (int b = 0; b < 4; b++) begin
          if (val_sel && wstrb_i[b]) begin
            val_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
          if (dat_sel && wstrb_i[b]) begin
            cnt_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (cfg_sel) begin
      rdata_o = {29'd0, cfg_q};
    end else if (val_sel) begin
      rdata_o = val_q;
    end else if (dat_sel) begin
      rdata_o = cnt_q;
    end
  end

  // irq was armed on the edge that fired it
  irq_needs_enable_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_o) |-> $past(cfg_q[hk_pkg::TIM_IRQEN_BIT])
  );

endmodule

/* source/hk_bus_fsm.sv */
`timescale 1ns/1ps

module hk_bus_fsm (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          mem_valid_i,
  input  hk_pkg::addr_t mem_addr_i,
  output logic          access_o,
  output logic          mem_ready_o
);

  hk_pkg::bus_state_e state_q;
  hk_pkg::bus_state_e state_d;
  logic               in_window;

  assign in_window = (mem_addr_i[31:8] == hk_pkg::HK_WINDOW);

  // accepted only from idle, so a held request is taken once
  assign access_o = (state_q == hk_pkg::IDLE) && mem_valid_i && in_window;

  always_comb begin
    state_d = state_q;
    case (state_q)
      hk_pkg::IDLE: begin
        if (access_o) begin
          state_d = hk_pkg::RESP;
        end
      end
      hk_pkg::RESP: begin
        state_d = hk_pkg::IDLE;
      end
      default: begin
        state_d = hk_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= hk_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign mem_ready_o = (state_q == hk_pkg::RESP);

  // single-cycle response
  ready_single_cycle_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_ready_o |=> !mem_ready_o
  );

endmodule

/* source/hk_pkg.sv */
package hk_pkg;

  // bus and register widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0] reg_ofs_t;
  typedef logic [3:0] strb_t;
  typedef logic [15:0] pad_vec_t;
  typedef logic [1:0] route_sel_t;

  typedef enum logic {
    IDLE,
    RESP
  } bus_state_e;

  // upper address bits of the housekeeping window
  localparam logic [23:0] HK_WINDOW = 24'h03_0000;

  // gpio pad registers
  localparam reg_ofs_t GPIO_DATA_OFS = 8'h00;
  localparam reg_ofs_t GPIO_OEB_OFS = 8'h04;
  localparam reg_ofs_t GPIO_PU_OFS = 8'h08;
  localparam reg_ofs_t GPIO_PD_OFS = 8'h0c;

  // read-only status words
  localparam reg_ofs_t CONFIG_OFS = 8'h18;
  localparam reg_ofs_t ENA_OFS = 8'h1c;
  localparam reg_ofs_t PLL_OFS = 8'h20;
  localparam reg_ofs_t MFGR_OFS = 8'h24;
  localparam reg_ofs_t PROD_OFS = 8'h28;
  localparam reg_ofs_t MASK_OFS = 8'h2c;
  localparam reg_ofs_t CLKSEL_OFS = 8'h30;

  // pad routing and irq source selectors
  localparam reg_ofs_t PLL_DEST_OFS = 8'h38;
  localparam reg_ofs_t TRAP_DEST_OFS = 8'h3c;
  localparam reg_ofs_t IRQ7_SRC_OFS = 8'h40;
  localparam reg_ofs_t IRQ8_SRC_OFS = 8'h44;

  // counter/timers
  localparam reg_ofs_t TIM0_BASE = 8'h5c;
  localparam reg_ofs_t TIM1_BASE = 8'h68;
  localparam reg_ofs_t TIM_CFG_REL = 8'h00;
  localparam reg_ofs_t TIM_VAL_REL = 8'h04;
  localparam reg_ofs_t TIM_DAT_REL = 8'h08;

  // timer config bits
  localparam int TIM_EN_BIT = 0;
  localparam int TIM_ONESHOT_BIT = 1;
  localparam int TIM_IRQEN_BIT = 2;

  // {tim1, tim0, irq8, irq7}
  localparam int IRQ_WIDTH = 4;

endpackage
